// ==== hw/lane_defs.svh ====
// ---------------------------------------------------------------------------
// Sizing macros for the operand conversion stage of one lane.
// The command length field limits a command to 255 output words.
// Queue depths below 1 are not supported.
// ---------------------------------------------------------------------------

`ifndef LANE_DEFS_SVH
`define LANE_DEFS_SVH

// Width of a register-file word
`define LANE_WORD_W 64

// Default number of words an operand queue can buffer
`define OPQ_DEPTH_DEFAULT 5

// Width of the command length field, in output words
`define OPQ_LEN_W 8

`endif

// ==== hw/lane_pkg.sv ====
// ---------------------------------------------------------------------------
// Types shared by the operand queues.
// The operand word union assumes a 64-bit register-file word.
// ---------------------------------------------------------------------------

`default_nettype none

`include "lane_defs.svh"

package lane_pkg;

  typedef logic [`LANE_WORD_W-1:0] word_t;

  // Source element width of a command
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } elem_width_e;

  // Conversion applied to every element
  typedef enum logic [1:0] {
    CONV_NONE = 2'd0,
    CONV_SEXT = 2'd1,
    CONV_ZEXT = 2'd2
  } conv_e;

  // One register-file word seen at each element width
  typedef union packed {
    logic [63:0]      w64;
    logic [1:0][31:0] w32;
    logic [3:0][15:0] w16;
    logic [7:0][7:0]  w8;
  } operand_word_u;

endpackage : lane_pkg

`default_nettype wire

// ==== hw/opqueue_cmd_ctrl.sv ====
// ---------------------------------------------------------------------------
// Holds one command at a time and counts its output words.
// A command with a length of zero is accepted and completes at once.
// active_o and last_o refer to words still to be loaded downstream.
// ---------------------------------------------------------------------------

`default_nettype none

`include "lane_defs.svh"

module opqueue_cmd_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cmd_valid_i,
  input  lane_pkg::elem_width_e cmd_ew_i,
  input  lane_pkg::conv_e       cmd_conv_i,
  input  logic [`OPQ_LEN_W-1:0] cmd_len_i,
  input  logic                  retire_i,
  output logic                  cmd_ready_o,
  output logic                  active_o,
  output lane_pkg::elem_width_e ew_o,
  output lane_pkg::conv_e       conv_o,
  output logic                  last_o
);

  import lane_pkg::*;

  logic                  active_q;
  logic [`OPQ_LEN_W-1:0] remaining_q;
  logic [`OPQ_LEN_W-1:0] to_load;
  elem_width_e           ew_q;
  conv_e                 conv_q;

  // Words not yet retired, minus the one retiring in this cycle.
  // The fan-out loads on the retire edge, so this is the count still to load
  assign to_load = remaining_q - {{(`OPQ_LEN_W-1){1'b0}}, retire_i};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q    <= 1'b0;
      remaining_q <= '0;
      ew_q        <= EW8;
      conv_q      <= CONV_NONE;
    end else if (!active_q) begin
      if (cmd_valid_i) begin
        active_q    <= (cmd_len_i != '0);
        remaining_q <= cmd_len_i;
        ew_q        <= cmd_ew_i;
        conv_q      <= cmd_conv_i;
      end
    end else if (retire_i) begin
      remaining_q <= to_load;
      // Idle again once the final word has retired
      active_q    <= (to_load != '0);
    end
  end

  assign cmd_ready_o = !active_q;
  assign active_o    = active_q && (to_load != '0);
  assign last_o      = active_q && (to_load == {{(`OPQ_LEN_W-1){1'b0}}, 1'b1});
  assign ew_o        = ew_q;
  assign conv_o      = conv_q;

endmodule : opqueue_cmd_ctrl

`default_nettype wire

// ==== hw/opqueue_buffer.sv ====
// ---------------------------------------------------------------------------
// Circular FIFO for issued register-file words.
// A push into a full buffer is dropped unless a pop happens in the same
// cycle. The upstream side is expected never to overfill it.
// ---------------------------------------------------------------------------

`default_nettype none

`include "lane_defs.svh"

module opqueue_buffer #(
  parameter int unsigned DEPTH = `OPQ_DEPTH_DEFAULT
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            push_i,
  input  lane_pkg::word_t data_i,
  input  logic            pop_i,
  output lane_pkg::word_t data_o,
  output logic            not_empty_o,
  output logic            full_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  lane_pkg::word_t  mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign do_pop  = pop_i && not_empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Fill level only moves when exactly one side is active
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign data_o      = mem_q[rd_ptr_q];
  assign not_empty_o = (count_q != '0);
  assign full_o      = (count_q == CNT_W'(DEPTH));

endmodule : opqueue_buffer

`default_nettype wire

// ==== hw/operand_widener.sv ====
// ---------------------------------------------------------------------------
// Converts the buffer head into one output word, or two when widening.
// Widening from EW64 is not defined and passes the word through unchanged.
// The low half always goes out before the high half.
// ---------------------------------------------------------------------------

`default_nettype none

module operand_widener (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  active_i,
  input  lane_pkg::elem_width_e ew_i,
  input  lane_pkg::conv_e       conv_i,
  input  logic                  last_i,
  input  lane_pkg::word_t       head_i,
  input  logic                  head_valid_i,
  input  logic                  sink_free_i,
  output logic                  pop_o,
  output logic                  load_o,
  output lane_pkg::word_t       word_o
);

  import lane_pkg::*;

  logic          half_q;
  logic          widen;
  logic          sext;
  operand_word_u in_u;
  operand_word_u out_u;

  assign widen = (conv_i != CONV_NONE);
  assign sext  = (conv_i == CONV_SEXT);

  // A word moves when a command wants it, the head exists and the sink is free
  assign load_o = active_i && head_valid_i && sink_free_i;

  // Pop after the high half, or early when the command ends on a low half
  assign pop_o = load_o && (!widen || half_q || last_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      half_q <= 1'b0;
    end else if (load_o && widen) begin
      half_q <= !pop_o;
    end
  end

  always_comb begin
    in_u.w64  = head_i;
    out_u.w64 = head_i;
    if (widen) begin
      case (ew_i)
        EW8: begin
          for (int i = 0; i < 4; i++) begin
            out_u.w16[i] = {{8{sext && in_u.w8[4*half_q + i][7]}},
                            in_u.w8[4*half_q + i]};
          end
        end
        EW16: begin
          for (int i = 0; i < 2; i++) begin
            out_u.w32[i] = {{16{sext && in_u.w16[2*half_q + i][15]}},
                            in_u.w16[2*half_q + i]};
          end
        end
        EW32: begin
          out_u.w64 = {{32{sext && in_u.w32[half_q][31]}}, in_u.w32[half_q]};
        end
        default: begin
          // Nothing wider than 64 bits exists
          out_u.w64 = head_i;
        end
      endcase
    end
  end

  assign word_o = out_u.w64;

endmodule : operand_widener

`default_nettype wire

// ==== hw/operand_fanout.sv ====
// ---------------------------------------------------------------------------
// Single-word output register shared by NR_SLAVES consumers.
// Each consumer takes the word once; a new word loads on the retire edge.
// ---------------------------------------------------------------------------

`default_nettype none

module operand_fanout #(
  parameter int unsigned NR_SLAVES = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 load_i,
  input  lane_pkg::word_t      word_i,
  input  logic [NR_SLAVES-1:0] ready_i,
  output logic                 free_o,
  output logic                 retire_o,
  output lane_pkg::word_t      operand_o,
  output logic [NR_SLAVES-1:0] valid_o
);

  lane_pkg::word_t      word_q;
  logic [NR_SLAVES-1:0] pending_q;
  logic [NR_SLAVES-1:0] still_pending;

  // Consumers that have not taken the word after this cycle
  assign still_pending = pending_q & ~ready_i;

  assign retire_o = (pending_q != '0) && (still_pending == '0);
  assign free_o   = (still_pending == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else if (load_i) begin
      pending_q <= '1;
    end else begin
      pending_q <= still_pending;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      word_q <= word_i;
    end
  end

  assign operand_o = word_q;
  assign valid_o   = pending_q;

endmodule : operand_fanout

`default_nettype wire

// ==== hw/opqueue.sv ====
// ---------------------------------------------------------------------------
// One operand queue: command control and word buffer, widener, fan-out.
// Words may be issued before their command and wait in the buffer.
// Upstream must not issue more words than IBUF_DEPTH can hold.
// ---------------------------------------------------------------------------

`default_nettype none

`include "lane_defs.svh"

module opqueue #(
  parameter int unsigned IBUF_DEPTH = `OPQ_DEPTH_DEFAULT,
  parameter int unsigned NR_SLAVES  = 1
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cmd_valid_i,
  input  lane_pkg::elem_width_e cmd_ew_i,
  input  lane_pkg::conv_e       cmd_conv_i,
  input  logic [`OPQ_LEN_W-1:0] cmd_len_i,
  output logic                  cmd_ready_o,
  input  lane_pkg::word_t       word_i,
  input  logic                  word_issued_i,
  output lane_pkg::word_t       operand_o,
  output logic [NR_SLAVES-1:0]  operand_valid_o,
  input  logic [NR_SLAVES-1:0]  operand_ready_i
);

  import lane_pkg::*;

  logic        cmd_active;
  logic        cmd_last;
  elem_width_e cmd_ew;
  conv_e       cmd_conv;
  logic        retire;
  word_t       head_word;
  logic        head_valid;
  logic        buf_full;
  logic        pop;
  logic        load;
  logic        sink_free;
  word_t       wide_word;

  // Input side
  opqueue_cmd_ctrl i_cmd_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cmd_valid_i(cmd_valid_i),
    .cmd_ew_i   (cmd_ew_i),
    .cmd_conv_i (cmd_conv_i),
    .cmd_len_i  (cmd_len_i),
    .retire_i   (retire),
    .cmd_ready_o(cmd_ready_o),
    .active_o   (cmd_active),
    .ew_o       (cmd_ew),
    .conv_o     (cmd_conv),
    .last_o     (cmd_last)
  );

  opqueue_buffer #(
    .DEPTH(IBUF_DEPTH)
  ) i_buffer (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .push_i     (word_issued_i),
    .data_i     (word_i),
    .pop_i      (pop),
    .data_o     (head_word),
    .not_empty_o(head_valid),
    .full_o     (buf_full)
  );

  operand_widener i_widener (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .active_i    (cmd_active),
    .ew_i        (cmd_ew),
    .conv_i      (cmd_conv),
    .last_i      (cmd_last),
    .head_i      (head_word),
    .head_valid_i(head_valid),
    .sink_free_i (sink_free),
    .pop_o       (pop),
    .load_o      (load),
    .word_o      (wide_word)
  );

  // Output side
  operand_fanout #(
    .NR_SLAVES(NR_SLAVES)
  ) i_fanout (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .load_i   (load),
    .word_i   (wide_word),
    .ready_i  (operand_ready_i),
    .free_o   (sink_free),
    .retire_o (retire),
    .operand_o(operand_o),
    .valid_o  (operand_valid_o)
  );

endmodule : opqueue

`default_nettype wire

// ==== hw/operand_stage.sv ====
// ---------------------------------------------------------------------------
// Operand conversion stage of one lane with two queues.
// ALU B queue: one consumer, five buffered words.
// Mask queue: bit 0 feeds the ALU, bit 1 the reduction unit, two words.
// ---------------------------------------------------------------------------

`default_nettype none

`include "lane_defs.svh"

module operand_stage (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // ALU B queue
  input  logic                  alub_cmd_valid_i,
  input  lane_pkg::elem_width_e alub_cmd_ew_i,
  input  lane_pkg::conv_e       alub_cmd_conv_i,
  input  logic [`OPQ_LEN_W-1:0] alub_cmd_len_i,
  output logic                  alub_cmd_ready_o,
  input  lane_pkg::word_t       alub_word_i,
  input  logic                  alub_word_issued_i,
  output lane_pkg::word_t       alub_operand_o,
  output logic                  alub_operand_valid_o,
  input  logic                  alub_operand_ready_i,
  // Mask queue
  input  logic                  mask_cmd_valid_i,
  input  lane_pkg::elem_width_e mask_cmd_ew_i,
  input  lane_pkg::conv_e       mask_cmd_conv_i,
  input  logic [`OPQ_LEN_W-1:0] mask_cmd_len_i,
  output logic                  mask_cmd_ready_o,
  input  lane_pkg::word_t       mask_word_i,
  input  logic                  mask_word_issued_i,
  output lane_pkg::word_t       mask_operand_o,
  output logic [1:0]            mask_operand_valid_o,
  input  logic [1:0]            mask_operand_ready_i
);

  opqueue #(
    .IBUF_DEPTH(`OPQ_DEPTH_DEFAULT),
    .NR_SLAVES (1)
  ) i_opqueue_alu_b (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_valid_i    (alub_cmd_valid_i),
    .cmd_ew_i       (alub_cmd_ew_i),
    .cmd_conv_i     (alub_cmd_conv_i),
    .cmd_len_i      (alub_cmd_len_i),
    .cmd_ready_o    (alub_cmd_ready_o),
    .word_i         (alub_word_i),
    .word_issued_i  (alub_word_issued_i),
    .operand_o      (alub_operand_o),
    .operand_valid_o(alub_operand_valid_o),
    .operand_ready_i(alub_operand_ready_i)
  );

  // Shared between the ALU and the reduction unit
  opqueue #(
    .IBUF_DEPTH(2),
    .NR_SLAVES (2)
  ) i_opqueue_mask (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_valid_i    (mask_cmd_valid_i),
    .cmd_ew_i       (mask_cmd_ew_i),
    .cmd_conv_i     (mask_cmd_conv_i),
    .cmd_len_i      (mask_cmd_len_i),
    .cmd_ready_o    (mask_cmd_ready_o),
    .word_i         (mask_word_i),
    .word_issued_i  (mask_word_issued_i),
    .operand_o      (mask_operand_o),
    .operand_valid_o(mask_operand_valid_o),
    .operand_ready_i(mask_operand_ready_i)
  );

endmodule : operand_stage

`default_nettype wire

// ==== verif/operand_stage_sva.sv ====
// ---------------------------------------------------------------------------
// Assertions for one operand queue, bound to every opqueue instance.
// Covers upstream limits, command legality and the consumer handshake.
// ---------------------------------------------------------------------------

`default_nettype none

module operand_stage_sva #(
  parameter int unsigned NR_SLAVES = 1
) (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic                  cmd_valid_i,
  input logic                  cmd_ready_i,
  input lane_pkg::elem_width_e cmd_ew_i,
  input lane_pkg::conv_e       cmd_conv_i,
  input logic                  word_issued_i,
  input logic                  buf_full_i,
  input lane_pkg::word_t       operand_i,
  input logic [NR_SLAVES-1:0]  operand_valid_i,
  input logic [NR_SLAVES-1:0]  operand_ready_i
);

  import lane_pkg::*;

  // Upstream never issues into a full buffer
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    word_issued_i |-> !buf_full_i)
    else $error("Word issued into a full operand buffer");

  // Nothing is wider than 64 bits
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cmd_valid_i && cmd_ready_i && cmd_conv_i != CONV_NONE) |-> (cmd_ew_i != EW64))
    else $error("Widening command accepted with 64-bit source elements");

  for (genvar i = 0; i < NR_SLAVES; i++) begin : g_hold
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (operand_valid_i[i] && !operand_ready_i[i]) |=>
        (operand_valid_i[i] && $stable(operand_i)))
      else $error("Operand dropped or changed before consumer %0d took it", i);
  end

  assert property (@(posedge clk_i) !rst_n_i |=> cmd_ready_i)
    else $error("Command ready low after reset");

endmodule : operand_stage_sva

`default_nettype wire

// ==== verif/operand_stage_tb.sv ====
// ---------------------------------------------------------------------------
// Testbench for the operand conversion stage, one test record at a time.
// Records come from verif/operand_stage_tests.txt, read from the project root.
// Upstream issue is throttled so that no queue buffer is ever overfilled.
// ---------------------------------------------------------------------------

`default_nettype none

`include "lane_defs.svh"

module operand_stage_tb;

  import lane_pkg::*;

  localparam int unsigned MASK_DEPTH = 2;
  localparam int unsigned MEM_WORDS  = 256;
  localparam string       TESTS_FILE = "verif/operand_stage_tests.txt";

  logic                  clk_i      = 1'b0;
  logic                  rst_n_i    = 1'b0;
  logic                  cur_q      = 1'b0;
  logic                  cmd_valid  = 1'b0;
  elem_width_e           cmd_ew     = EW8;
  conv_e                 cmd_conv   = CONV_NONE;
  logic [`OPQ_LEN_W-1:0] cmd_len    = '0;
  word_t                 issue_word = '0;
  logic                  issue      = 1'b0;
  logic [1:0]            cons_ready = 2'b00;
  logic [15:0]           lfsr_q     = 16'd5623;
  int unsigned           limit_cycles = 0;

  logic       alub_cmd_ready;
  logic       mask_cmd_ready;
  word_t      alub_operand;
  word_t      mask_operand;
  logic       alub_valid;
  logic [1:0] mask_valid;
  word_t      cur_operand;
  logic [1:0] cur_valid;
  logic       cur_cmd_ready;

  // Header, input words, expected words of each record
  word_t       tests_mem [MEM_WORDS];
  int unsigned record_base [$];

  always #5 clk_i = ~clk_i;

  // Outputs of the queue under test
  assign cur_operand   = cur_q ? mask_operand : alub_operand;
  assign cur_valid     = cur_q ? mask_valid : {1'b0, alub_valid};
  assign cur_cmd_ready = cur_q ? mask_cmd_ready : alub_cmd_ready;

  operand_stage UUT (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .alub_cmd_valid_i    (cmd_valid && !cur_q),
    .alub_cmd_ew_i       (cmd_ew),
    .alub_cmd_conv_i     (cmd_conv),
    .alub_cmd_len_i      (cmd_len),
    .alub_cmd_ready_o    (alub_cmd_ready),
    .alub_word_i         (issue_word),
    .alub_word_issued_i  (issue && !cur_q),
    .alub_operand_o      (alub_operand),
    .alub_operand_valid_o(alub_valid),
    .alub_operand_ready_i(cons_ready[0] && !cur_q),
    .mask_cmd_valid_i    (cmd_valid && cur_q),
    .mask_cmd_ew_i       (cmd_ew),
    .mask_cmd_conv_i     (cmd_conv),
    .mask_cmd_len_i      (cmd_len),
    .mask_cmd_ready_o    (mask_cmd_ready),
    .mask_word_i         (issue_word),
    .mask_word_issued_i  (issue && cur_q),
    .mask_operand_o      (mask_operand),
    .mask_operand_valid_o(mask_valid),
    .mask_operand_ready_i(cur_q ? cons_ready : 2'b00)
  );

  bind opqueue operand_stage_sva #(
    .NR_SLAVES(NR_SLAVES)
  ) i_sva (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_i    (cmd_ready_o),
    .cmd_ew_i       (cmd_ew_i),
    .cmd_conv_i     (cmd_conv_i),
    .word_issued_i  (word_issued_i),
    .buf_full_i     (buf_full),
    .operand_i      (operand_o),
    .operand_valid_i(operand_valid_o),
    .operand_ready_i(operand_ready_i)
  );

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "Run stopped at time %0t", $time);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic take_random_bit(output logic bit_o);
    lfsr_q = lfsr_step(lfsr_q);
    bit_o  = lfsr_q[0];
  endtask

  // Queue select in bit 28, length in the low byte, upper bits zero
  function automatic bit is_header(input word_t hdr);
    return (hdr[63:29] == '0) && (hdr[7:0] != 8'h00);
  endfunction

  task automatic run_record(input int unsigned base);
    word_t       hdr;
    int unsigned nin;
    int unsigned len;
    int unsigned bp;
    int unsigned depth;
    int unsigned nr_cons;
    int unsigned exp_base;
    int unsigned issued;
    int unsigned inputs_done;
    int unsigned taken [2];
    logic        rnd;
    bit          first;
    bit          done;

    hdr      = tests_mem[base];
    nin      = int'(hdr[15:8]);
    len      = int'(hdr[7:0]);
    bp       = int'(hdr[19:16]);
    exp_base = base + 1 + nin;
    issued   = 0;
    taken[0] = 0;
    taken[1] = 0;
    first    = 1'b1;

    @(posedge clk_i);
    #1;
    cur_q     = hdr[28];
    cmd_ew    = elem_width_e'(hdr[25:24]);
    cmd_conv  = conv_e'(hdr[21:20]);
    cmd_len   = hdr[7:0];
    cmd_valid = 1'b1;
    nr_cons   = cur_q ? 2 : 1;
    depth     = cur_q ? MASK_DEPTH : `OPQ_DEPTH_DEFAULT;
    #4;
    check_flag("cmd_ready_o before command", cur_cmd_ready, 1'b1);

    do begin
      @(posedge clk_i);
      #1;
      cmd_valid = 1'b0;
      // Inputs surely popped, judged from the words all consumers took
      inputs_done = (nr_cons == 1 || taken[0] < taken[1]) ? taken[0] : taken[1];
      if (cmd_conv != CONV_NONE) begin
        inputs_done = inputs_done / 2;
      end
      issue = 1'b0;
      if (issued < nin && (issued - inputs_done) < depth) begin
        issue      = 1'b1;
        issue_word = tests_mem[base + 1 + issued];
        issued++;
      end
      for (int j = 0; j < 2; j++) begin
        case (bp)
          0: cons_ready[j] = 1'b1;
          1: begin
            rnd = 1'b0;
            if (j < nr_cons) begin
              take_random_bit(rnd);
            end
            cons_ready[j] = rnd;
          end
          // Stalled until every input word has been written into the queue
          default: cons_ready[j] = (issued == nin) && !issue;
        endcase
      end
      #4;
      if (first) begin
        check_flag("cmd_ready_o after acceptance", cur_cmd_ready, 1'b0);
        first = 1'b0;
      end
      for (int j = 0; j < nr_cons; j++) begin
        if (cur_valid[j]) begin
          if (taken[j] >= len) begin
            stop_with_failure($sformatf(
              "Consumer %0d was offered more words than the command length", j));
          end
          if (cons_ready[j]) begin
            check_word($sformatf("operand_o consumer %0d", j), cur_operand,
                       tests_mem[exp_base + taken[j]]);
            taken[j]++;
          end
        end
      end
      done = (taken[0] == len) && (nr_cons == 1 || taken[1] == len);
    end while (!done);

    @(posedge clk_i);
    #1;
    issue      = 1'b0;
    cons_ready = 2'b00;
    #4;
    check_flag("cmd_ready_o after command", cur_cmd_ready, 1'b1);
    check_flag("operand_valid_o after command", |cur_valid, 1'b0);
  endtask

  initial begin : main
    int unsigned ptr;
    int unsigned nin;
    int unsigned len;

    $readmemh(TESTS_FILE, tests_mem);
    ptr = 0;
    while (ptr < MEM_WORDS && is_header(tests_mem[ptr])) begin
      nin = int'(tests_mem[ptr][15:8]);
      len = int'(tests_mem[ptr][7:0]);
      if (ptr + 1 + nin + len > MEM_WORDS) begin
        break;
      end
      record_base.push_back(ptr);
      ptr = ptr + 1 + nin + len;
    end
    limit_cycles = 40 * record_base.size() + 100;

    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    #4;
    check_flag("alub_cmd_ready_o after reset", alub_cmd_ready, 1'b1);
    check_flag("mask_cmd_ready_o after reset", mask_cmd_ready, 1'b1);
    check_flag("alub_operand_valid_o after reset", alub_valid, 1'b0);
    check_flag("mask_operand_valid_o after reset", |mask_valid, 1'b0);

    foreach (record_base[i]) begin
      run_record(record_base[i]);
    end

    if (record_base.size() > 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      stop_with_failure("No test records were found in the stimulus file");
    end
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    stop_with_failure("Watchdog expired before all test records completed");
  end

endmodule : operand_stage_tb

`default_nettype wire

// ==== verif/operand_stage_tests.txt ====
// Header word QECBNNLL: Q queue (0 ALU B, 1 mask), E source width, C conversion,
// B back-pressure (0 ready, 1 random, 2 stall), NN input words, LL output words.
// Each header and its input words are followed by a line of expected output words.
03000303 0123456789abcdef fedcba9876543210 00000000deadbeef
0123456789abcdef fedcba9876543210 00000000deadbeef
00110102 807f01ff40c00081
0040ffc00000ff81 ff80007f0001ffff
01100102 80007fffffff1234
ffffffff00001234 ffff800000007fff
02110204 7fffffff80000000 00000001fffffffe
ffffffff80000000 000000007fffffff fffffffffffffffe 0000000000000001
10210203 8899aabbccddeeff 0102030405060708
00cc00dd00ee00ff 0088009900aa00bb 0005000600070008
13010404 1111111111111111 2222222222222222 3333333333333333 4444444444444444
1111111111111111 2222222222222222 3333333333333333 4444444444444444
03020505 a5a5a5a500000001 a5a5a5a500000002 a5a5a5a500000003 a5a5a5a500000004 a5a5a5a500000005
a5a5a5a500000001 a5a5a5a500000002 a5a5a5a500000003 a5a5a5a500000004 a5a5a5a500000005
11200102 8000ffff00017fff
0000000100007fff 000080000000ffff
F0000000

// ==== vlog.f ====
+incdir+hw
hw/lane_pkg.sv
hw/opqueue_cmd_ctrl.sv
hw/opqueue_buffer.sv
hw/operand_widener.sv
hw/operand_fanout.sv
hw/opqueue.sv
hw/operand_stage.sv
verif/operand_stage_sva.sv
verif/operand_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the operand stage testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module operand_stage_tb -o operand_stage_sim
./obj_dir/operand_stage_sim
